/* bus_top.f */
src/bus_pkg.sv
src/data_ram.sv
src/inst_rom.sv
src/uart_tx.sv
src/digseg_driver.sv
src/bus_top.sv
test/bus_top_properties.sv
test/bus_top_tb.sv

/* src/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	// Bus address and data word
	typedef logic [31:0] bus_word_t;

	// Device-select code
	typedef logic [3:0] select_t;

	localparam select_t SEL_ZERO      = 4'd0;
	localparam select_t SEL_RAM       = 4'd1;
	localparam select_t SEL_ROM       = 4'd2;
	localparam select_t SEL_UART      = 4'd3;
	localparam select_t SEL_UART_STAT = 4'd4;
	localparam select_t SEL_DIGSEG    = 4'd5;

	// 256-word data RAM
	localparam int RAM_AWIDTH = 8;
	typedef logic [RAM_AWIDTH-1:0] ram_addr_t;

	// 64-word instruction ROM
	localparam int ROM_AWIDTH = 6;
	typedef logic [ROM_AWIDTH-1:0] rom_addr_t;

	typedef logic [7:0] byte_t;

	// Active-high segments a to g from the top bit down
	typedef logic [6:0] seg_t;

	localparam int UART_CLKS_PER_BIT = 4;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		DONE
	} bus_state_t;

endpackage

`default_nettype wire

/* src/bus_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_top (
	input  logic                clk,
	input  logic                reset_i,
	input  bus_pkg::bus_word_t  wb_addr_i,
	input  bus_pkg::bus_word_t  wb_data_i,
	input  logic                wb_we_i,
	input  logic                wb_stb_i,
	input  bus_pkg::select_t    wb_select_i,
	output bus_pkg::bus_word_t  wb_data_o,
	output logic                wb_ack_o,
	output logic                uart_txd_o,
	output logic                uart_busy_o,
	output bus_pkg::seg_t       digseg_seg1_o,
	output bus_pkg::seg_t       digseg_seg0_o
);

	import bus_pkg::*;

	bus_state_t state;

	logic ram_req;
	logic rom_req;
	logic uart_req;
	logic seg_req;

	logic ram_ack;
	logic rom_ack;
	logic uart_ack;
	logic seg_ack;

	bus_word_t ram_rdata;
	bus_word_t rom_rdata;
	byte_t     seg_rdata;

	logic ram_sel;
	logic rom_sel;
	logic uart_sel;
	logic seg_sel;
	logic dev_sel;
	logic dev_ack;

	bus_word_t imm_data;
	bus_word_t dev_rdata;

	// Decode which device, if any, takes the transfer
	always_comb begin
		ram_sel = 1'b0;
		rom_sel = 1'b0;
		uart_sel = 1'b0;
		seg_sel = 1'b0;
		imm_data = '0;
		case (wb_select_i)
			SEL_ZERO: begin
				// Answered at once with zero data
			end
			SEL_RAM: ram_sel = 1'b1;
			SEL_ROM: rom_sel = !wb_we_i;
			SEL_UART: uart_sel = wb_we_i;
			SEL_UART_STAT: imm_data = bus_word_t'(uart_busy_o);
			SEL_DIGSEG: seg_sel = 1'b1;
			default: begin
			end
		endcase
	end

	assign dev_sel = ram_sel | rom_sel | uart_sel | seg_sel;

	// Only one request is ever up, so at most one acknowledge fires
	assign dev_ack = ram_ack | rom_ack | uart_ack | seg_ack;

	always_comb begin
		case (wb_select_i)
			SEL_RAM: dev_rdata = ram_rdata;
			SEL_ROM: dev_rdata = rom_rdata;
			SEL_DIGSEG: dev_rdata = bus_word_t'(seg_rdata);
			default: dev_rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= IDLE;
			wb_ack_o <= 1'b0;
			ram_req <= 1'b0;
			rom_req <= 1'b0;
			uart_req <= 1'b0;
			seg_req <= 1'b0;
		end else begin
			wb_ack_o <= 1'b0;
			case (state)
				IDLE: begin
					if (wb_stb_i) begin
						ram_req <= ram_sel;
						rom_req <= rom_sel;
						uart_req <= uart_sel;
						seg_req <= seg_sel;
						if (dev_sel) begin
							state <= ACCESS;
						end else begin
							wb_ack_o <= 1'b1;
							state <= DONE;
						end
					end
				end
				ACCESS: begin
					// A busy UART keeps us here until it takes the byte
					if (dev_ack) begin
						ram_req <= 1'b0;
						rom_req <= 1'b0;
						uart_req <= 1'b0;
						seg_req <= 1'b0;
						wb_ack_o <= 1'b1;
						state <= DONE;
					end
				end
				DONE: begin
					if (!wb_stb_i) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && wb_stb_i && !dev_sel) begin
			wb_data_o <= imm_data;
		end else if (state == ACCESS && dev_ack) begin
			wb_data_o <= dev_rdata;
		end
	end

	data_ram i_data_ram (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (ram_req),
		.we_i    (wb_we_i),
		.addr_i  (wb_addr_i[RAM_AWIDTH+1:2]),
		.wdata_i (wb_data_i),
		.rdata_o (ram_rdata),
		.ack_o   (ram_ack)
	);

	inst_rom i_inst_rom (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (rom_req),
		.addr_i  (wb_addr_i[ROM_AWIDTH+1:2]),
		.rdata_o (rom_rdata),
		.ack_o   (rom_ack)
	);

	uart_tx i_uart_tx (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (uart_req),
		.data_i  (wb_data_i[7:0]),
		.ack_o   (uart_ack),
		.busy_o  (uart_busy_o),
		.txd_o   (uart_txd_o)
	);

	digseg_driver i_digseg_driver (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (seg_req),
		.we_i    (wb_we_i),
		.data_i  (wb_data_i[7:0]),
		.data_o  (seg_rdata),
		.ack_o   (seg_ack),
		.seg1_o  (digseg_seg1_o),
		.seg0_o  (digseg_seg0_o)
	);

endmodule

`default_nettype wire

/* src/data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module data_ram (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                req_i,
	input  logic                we_i,
	input  bus_pkg::ram_addr_t  addr_i,
	input  bus_pkg::bus_word_t  wdata_i,
	output bus_pkg::bus_word_t  rdata_o,
	output logic                ack_o
);

	import bus_pkg::*;

	bus_word_t mem [0:(1 << RAM_AWIDTH)-1];

	logic access;

	// First cycle of a request only
	assign access = req_i && !ack_o;

	always_ff @(posedge clk) begin
		if (access) begin
			if (we_i) begin
				mem[addr_i] <= wdata_i;
			end else begin
				rdata_o <= mem[addr_i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

endmodule

`default_nettype wire

/* src/digseg_driver.sv */
`timescale 1ns/10ps
`default_nettype none

module digseg_driver (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            req_i,
	input  logic            we_i,
	input  bus_pkg::byte_t  data_i,
	output bus_pkg::byte_t  data_o,
	output logic            ack_o,
	output bus_pkg::seg_t   seg1_o,
	output bus_pkg::seg_t   seg0_o
);

	import bus_pkg::*;

	byte_t data_q;

	function automatic seg_t hex_to_seg(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'h7E;
			4'h1: return 7'h30;
			4'h2: return 7'h6D;
			4'h3: return 7'h79;
			4'h4: return 7'h33;
			4'h5: return 7'h5B;
			4'h6: return 7'h5F;
			4'h7: return 7'h70;
			4'h8: return 7'h7F;
			4'h9: return 7'h7B;
			4'hA: return 7'h77;
			4'hB: return 7'h1F;
			4'hC: return 7'h4E;
			4'hD: return 7'h3D;
			4'hE: return 7'h4F;
			default: return 7'h47;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (reset_i) begin
			data_q <= '0;
			ack_o <= 1'b0;
		end else begin
			ack_o <= req_i && !ack_o;
			if (req_i && !ack_o && we_i) begin
				data_q <= data_i;
			end
		end
	end

	// Reads see the latched byte
	assign data_o = data_q;

	assign seg1_o = hex_to_seg(data_q[7:4]);
	assign seg0_o = hex_to_seg(data_q[3:0]);

endmodule

`default_nettype wire

/* src/inst_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_rom (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                req_i,
	input  bus_pkg::rom_addr_t  addr_i,
	output bus_pkg::bus_word_t  rdata_o,
	output logic                ack_o
);

	import bus_pkg::*;

	bus_word_t rom [0:(1 << ROM_AWIDTH)-1];

	// Word n holds C0DE in the upper half and n below
	for (genvar n = 0; n < (1 << ROM_AWIDTH); n++) begin : g_rom
		assign rom[n] = {16'hC0DE, 16'(n)};
	end

	always_ff @(posedge clk) begin
		if (req_i && !ack_o) begin
			rdata_o <= rom[addr_i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req_i && !ack_o;
		end
	end

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            req_i,
	input  bus_pkg::byte_t  data_i,
	output logic            ack_o,
	output logic            busy_o,
	output logic            txd_o
);

	import bus_pkg::*;

	typedef logic [$clog2(UART_CLKS_PER_BIT)-1:0] baud_cnt_t;

	baud_cnt_t  baud_cnt;
	logic [3:0] bit_cnt;

	// Data bits still to go, with the stop bit shifted in behind them
	logic [8:0] shift_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_o <= 1'b0;
			busy_o <= 1'b0;
			txd_o <= 1'b1;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			ack_o <= 1'b0;
			if (!busy_o) begin
				if (req_i) begin
					// Start bit goes out straight away
					shift_q <= {1'b1, data_i};
					txd_o <= 1'b0;
					busy_o <= 1'b1;
					ack_o <= 1'b1;
					baud_cnt <= '0;
					bit_cnt <= '0;
				end
			end else if (baud_cnt == baud_cnt_t'(UART_CLKS_PER_BIT - 1)) begin
				baud_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					// Stop bit done and the line stays high
					busy_o <= 1'b0;
				end else begin
					txd_o <= shift_q[0];
					shift_q <= {1'b1, shift_q[8:1]};
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/bus_top_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_top_properties (
	input logic clk,
	input logic reset_i,
	input logic stb_i,
	input logic ack_i,
	input logic ram_req_i,
	input logic rom_req_i,
	input logic uart_req_i,
	input logic seg_req_i
);

	// Number of failed assertions
	int fail_count = 0;

	ack_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
		ack_i |=> !ack_i)
		else begin
			fail_count++;
			$error("wb_ack_o held for more than one cycle");
		end

	// Strobe seen at the edge that raised the acknowledge
	ack_needs_stb: assert property (@(posedge clk) disable iff (reset_i)
		$rose(ack_i) |-> $past(stb_i))
		else begin
			fail_count++;
			$error("wb_ack_o rose without wb_stb_i");
		end

	one_request: assert property (@(posedge clk) disable iff (reset_i)
		$onehot0({ram_req_i, rom_req_i, uart_req_i, seg_req_i}))
		else begin
			fail_count++;
			$error("more than one device request high");
		end

endmodule

bind bus_top bus_top_properties i_bus_top_properties (
	.clk        (clk),
	.reset_i    (reset_i),
	.stb_i      (wb_stb_i),
	.ack_i      (wb_ack_o),
	.ram_req_i  (ram_req),
	.rom_req_i  (rom_req),
	.uart_req_i (uart_req),
	.seg_req_i  (seg_req)
);

`default_nettype wire

/* test/bus_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_top_tb;

	import bus_pkg::*;

	typedef struct {
		select_t   sel;
		logic      we;
		bus_word_t addr;
		bus_word_t data;
		bus_word_t exp_data;
		int        lat;
		int        need_rx;
	} xfer_t;

	localparam int ACK_LIMIT = 200;
	localparam int RX_LIMIT = 3000;

	// Segments a to g from the top bit down
	localparam seg_t HEX_SEG [16] = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
		7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47};

	logic      clk;
	logic      reset_i;
	bus_word_t wb_addr_i;
	bus_word_t wb_data_i;
	logic      wb_we_i;
	logic      wb_stb_i;
	select_t   wb_select_i;
	bus_word_t wb_data_o;
	logic      wb_ack_o;
	logic      uart_txd_o;
	logic      uart_busy_o;
	seg_t      digseg_seg1_o;
	seg_t      digseg_seg0_o;

	xfer_t  xfers[$];
	byte_t  rx_q[$];
	byte_t  exp_rx[$];
	int     errors;
	int     timeouts;
	int     assert_fails;
	int     uart_sent;
	integer seed;
	logic   abort;

	bus_top i_dut (
		.clk           (clk),
		.reset_i       (reset_i),
		.wb_addr_i     (wb_addr_i),
		.wb_data_i     (wb_data_i),
		.wb_we_i       (wb_we_i),
		.wb_stb_i      (wb_stb_i),
		.wb_select_i   (wb_select_i),
		.wb_data_o     (wb_data_o),
		.wb_ack_o      (wb_ack_o),
		.uart_txd_o    (uart_txd_o),
		.uart_busy_o   (uart_busy_o),
		.digseg_seg1_o (digseg_seg1_o),
		.digseg_seg0_o (digseg_seg0_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("[ERROR] %0t wb_ack_o latency: got %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic add_xfer(input select_t sel, input logic we, input bus_word_t addr,
			input bus_word_t data, input bus_word_t exp_data, input int lat, input int need_rx);
		xfer_t x;
		x.sel = sel;
		x.we = we;
		x.addr = addr;
		x.data = data;
		x.exp_data = exp_data;
		x.lat = lat;
		x.need_rx = need_rx;
		xfers.push_back(x);
		if (sel == SEL_UART && we) begin
			exp_rx.push_back(data[7:0]);
		end
	endtask

	task automatic build_table();
		bus_word_t words [4];
		bus_word_t addrs [4];
		int        rom_idx [3];
		addrs = '{32'h000, 32'h004, 32'h1FC, 32'h3FC};
		rom_idx = '{0, 5, 63};
		foreach (words[i]) begin
			words[i] = $random(seed);
			add_xfer(SEL_RAM, 1'b1, addrs[i], words[i], '0, 3, 0);
		end
		foreach (words[i]) begin
			add_xfer(SEL_RAM, 1'b0, addrs[i], '0, words[i], 3, 0);
		end
		foreach (rom_idx[i]) begin
			add_xfer(SEL_ROM, 1'b0, rom_idx[i] << 2, '0, {16'hC0DE, 16'(rom_idx[i])}, 3, 0);
		end
		// ROM write is answered at once and changes nothing
		add_xfer(SEL_ROM, 1'b1, 32'h14, 32'hFFFF_FFFF, '0, 1, 0);
		add_xfer(SEL_ROM, 1'b0, 32'h14, '0, 32'hC0DE_0005, 3, 0);
		add_xfer(SEL_UART, 1'b0, '0, '0, '0, 1, 0);
		add_xfer(SEL_DIGSEG, 1'b1, '0, 32'h9E, '0, 3, 0);
		add_xfer(SEL_DIGSEG, 1'b0, '0, '0, 32'h9E, 3, 0);
		add_xfer(4'hB, 1'b0, '0, '0, '0, 1, 0);
		add_xfer(SEL_DIGSEG, 1'b1, '0, 32'h2C, '0, 3, 0);
		add_xfer(SEL_DIGSEG, 1'b0, '0, '0, 32'h2C, 3, 0);
		add_xfer(SEL_ZERO, 1'b0, '0, '0, '0, 1, 0);
		add_xfer(SEL_UART, 1'b1, '0, 32'hA5, '0, 3, 0);
		add_xfer(SEL_UART_STAT, 1'b0, '0, '0, 32'h1, 1, 0);
		// Second byte stalls until the first frame is out
		add_xfer(SEL_UART, 1'b1, '0, 32'h3C, '0, 0, 0);
		add_xfer(SEL_UART_STAT, 1'b0, '0, '0, 32'h1, 1, 0);
		add_xfer(SEL_UART_STAT, 1'b0, '0, '0, 32'h0, 1, 2);
	endtask

	// Samples each bit in its middle
	task automatic receive_byte();
		byte_t b;
		int    cnt;
		logic  found;
		cnt = 0;
		found = 1'b0;
		while (!found && cnt < RX_LIMIT) begin
			@(posedge clk);
			#1;
			cnt++;
			found = (uart_txd_o === 1'b0);
		end
		if (!found) begin
			timeouts++;
			$display("Timeout waiting for a UART start bit at %0t", $time);
		end else begin
			repeat (UART_CLKS_PER_BIT / 2) @(posedge clk);
			#1;
			check_bit("uart_txd_o start bit", uart_txd_o, 1'b0);
			check_bit("uart_busy_o", uart_busy_o, 1'b1);
			for (int i = 0; i < 8; i++) begin
				repeat (UART_CLKS_PER_BIT) @(posedge clk);
				#1;
				b[i] = uart_txd_o;
			end
			repeat (UART_CLKS_PER_BIT) @(posedge clk);
			#1;
			check_bit("uart_txd_o stop bit", uart_txd_o, 1'b1);
			repeat (UART_CLKS_PER_BIT / 2) @(posedge clk);
			#1;
			rx_q.push_back(b);
		end
	endtask

	// Entered and left at edge plus 2 ns
	task automatic apply_xfer(input xfer_t x);
		int   cnt;
		logic acked;
		cnt = 0;
		while (rx_q.size() < x.need_rx && cnt < RX_LIMIT) begin
			@(posedge clk);
			#2;
			cnt++;
		end
		if (rx_q.size() < x.need_rx) begin
			timeouts++;
			abort = 1'b1;
			$display("Timeout waiting for UART frames to finish at %0t", $time);
		end else begin
			wb_select_i = x.sel;
			wb_we_i = x.we;
			wb_addr_i = x.addr;
			wb_data_i = x.data;
			wb_stb_i = 1'b1;
			cnt = 0;
			acked = 1'b0;
			while (!acked && cnt < ACK_LIMIT) begin
				@(posedge clk);
				#1;
				cnt++;
				acked = (wb_ack_o === 1'b1);
			end
			#1;
			if (!acked) begin
				timeouts++;
				abort = 1'b1;
				$display("Timeout waiting for wb_ack_o, select %0d at %0t", x.sel, $time);
			end else begin
				if (x.lat > 0) begin
					check_latency(cnt, x.lat);
				end
				if (!x.we) begin
					check_word("wb_data_o", wb_data_o, x.exp_data);
				end
				if (x.sel == SEL_UART && x.we) begin
					if (rx_q.size() != uart_sent) begin
						errors++;
						$display("UART write acknowledged before the earlier frame ended at %0t",
							$time);
					end
					uart_sent++;
				end
				if (x.sel == SEL_DIGSEG && x.we) begin
					check_seg("digseg_seg1_o", digseg_seg1_o, HEX_SEG[x.data[7:4]]);
					check_seg("digseg_seg0_o", digseg_seg0_o, HEX_SEG[x.data[3:0]]);
				end
			end
			wb_stb_i = 1'b0;
			@(posedge clk);
			#2;
		end
	endtask

	initial begin
		seed = 32'h7d94fb10;
		errors = 0;
		timeouts = 0;
		assert_fails = 0;
		uart_sent = 0;
		abort = 1'b0;
		reset_i = 1'b1;
		wb_addr_i = '0;
		wb_data_i = '0;
		wb_we_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_select_i = SEL_ZERO;
		repeat (5) @(posedge clk);
		#2;
		reset_i = 1'b0;
		check_seg("digseg_seg1_o", digseg_seg1_o, HEX_SEG[0]);
		check_seg("digseg_seg0_o", digseg_seg0_o, HEX_SEG[0]);
		check_bit("uart_txd_o", uart_txd_o, 1'b1);
		check_bit("uart_busy_o", uart_busy_o, 1'b0);
		build_table();
		fork
			begin
				foreach (xfers[i]) begin
					if (!abort) begin
						apply_xfer(xfers[i]);
					end
				end
			end
			begin
				foreach (exp_rx[i]) begin
					if (!abort) begin
						receive_byte();
					end
				end
			end
		join
		if (rx_q.size() != exp_rx.size()) begin
			errors++;
			$display("Received %0d UART bytes instead of %0d", rx_q.size(), exp_rx.size());
		end else begin
			foreach (exp_rx[i]) begin
				check_byte("uart_txd_o byte", rx_q[i], exp_rx[i]);
			end
		end
		assert_fails = i_dut.i_bus_top_properties.fail_count;
		$display("Value errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, assert_fails);
		if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
